// ==== hdl/sched_pkg.sv ====
`default_nettype none

package sched_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  localparam int NUM_SLOTS = 8;
  localparam int SLOT_W    = 3;
  localparam int ADDR_W    = 32;
  localparam int OFFS_W    = 12;              // word offset inside a page
  localparam int PAGE_W    = ADDR_W - OFFS_W;
  localparam int BLK_W     = 6;               // blocks of up to 63 words
  localparam int SECT_W    = 2;
  localparam int LEN_W     = ADDR_W - 1 - SECT_W;

  // carousel positions
  localparam int GB1_POS = 96;  // slot 1 fast trigger
  localparam int MB_POS  = 2;   // slow slots

  // ----------------------------------------
  // descriptor word
  // ----------------------------------------
  typedef struct packed {
    logic              active;
    logic [SECT_W-1:0] section;
    logic [LEN_W-1:0]  len;
    logic [ADDR_W-1:0] addr;
  } desc_fields_t;

  typedef struct packed {
    logic [31:0] hi;
    logic [31:0] lo;
  } desc_raw_t;

  typedef union packed {
    desc_fields_t f;    // scheduler view
    desc_raw_t    raw;  // cpu view
  } desc_t;

endpackage

`default_nettype wire

// ==== hdl/exec_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface exec_if;
  import sched_pkg::*;

  // command, scheduler to splitter
  logic              go;            // level, held until ready drops
  logic [BLK_W-1:0]  block_length;
  logic [ADDR_W-1:0] new_addr;
  logic [SECT_W-1:0] new_section;

  // status, splitter to scheduler
  logic              ready;         // high while splitter idle
  logic [ADDR_W-1:0] old_addr;      // first word after the block
  logic              endof_page;
  logic [BLK_W-1:0]  count_sent;

  modport sched (
    output go, block_length, new_addr, new_section,
    input  ready, old_addr, endof_page, count_sent
  );

  modport splitter (
    input  go, block_length, new_addr, new_section,
    output ready, old_addr, endof_page, count_sent
  );

endinterface

`default_nettype wire

// ==== hdl/desc_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module desc_mem (
  input  wire                          CLK,
  input  wire                          RST,
  // cpu side
  input  wire                          read_cpu,
  input  wire                          write_cpu,
  output logic                         read_cpu_ack,
  output logic                         write_cpu_ack,
  input  wire  [sched_pkg::SLOT_W-1:0] addr_cpu,
  input  wire  sched_pkg::desc_t       in_cpu,
  output logic [31:0]                  out_cpu,
  // scheduler side
  input  wire                          rd_sched,
  input  wire  [sched_pkg::SLOT_W-1:0] rd_addr,
  output sched_pkg::desc_t             rd_data,
  input  wire                          wr_sched,
  input  wire  [sched_pkg::SLOT_W-1:0] wr_addr,
  input  wire  sched_pkg::desc_t       wr_data
);
  import sched_pkg::*;

  desc_t             mem [NUM_SLOTS];
  logic [SLOT_W-1:0] read_addr;
  logic              read_sched_r;
  logic              cpu_rd_ok, cpu_wr_ok;
  logic [SLOT_W-1:0] write_addr;
  desc_t             write_data;

  // scheduler first on both ports, cpu waits
  assign cpu_rd_ok  = read_cpu && !rd_sched && !read_cpu_ack;
  assign cpu_wr_ok  = write_cpu && !wr_sched && !write_cpu_ack;
  assign write_addr = wr_sched ? wr_addr : addr_cpu;
  assign write_data = wr_sched ? wr_data : in_cpu;

  always_ff @(posedge CLK)
    if (!RST)
    begin
      read_sched_r  <= 1'b0;
      read_cpu_ack  <= 1'b0;
      write_cpu_ack <= 1'b0;
      for (int i = 0; i < NUM_SLOTS; i++)
        mem[i] <= '0;
    end
    else
    begin
      read_sched_r  <= rd_sched;
      read_cpu_ack  <= cpu_rd_ok;   // doubles as the cpu read stage
      write_cpu_ack <= cpu_wr_ok;
      if (wr_sched || cpu_wr_ok)
        mem[write_addr] <= write_data;
    end

  // read path, address stage then data stage
  always_ff @(posedge CLK)
  begin
    if (rd_sched)
      read_addr <= rd_addr;
    else if (cpu_rd_ok)
      read_addr <= addr_cpu;
    if (read_sched_r)
      rd_data <= mem[read_addr];
    if (read_cpu_ack)
      out_cpu <= mem[read_addr].raw.hi;
  end

endmodule

`default_nettype wire

// ==== hdl/slot_carousel.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_carousel #(
  parameter int CYCLE_LEN = 192
) (
  input  wire                          CLK,
  input  wire                          RST,
  output logic                         trg_slot,
  output logic [sched_pkg::SLOT_W-1:0] trg_index,
  output logic                         refresh_req
);
  import sched_pkg::*;

  localparam int SMALL_W = $clog2(CYCLE_LEN + 2);
  localparam int BIG_W   = 4;   // 16 big steps

  logic [SMALL_W-1:0] small_cnt;
  logic [BIG_W-1:0]   big_cnt;
  logic               small_wrap;
  logic               at_fast0, at_fast1, at_slow, slow_step;

  // also catches the out-of-range start value
  assign small_wrap = small_cnt >= SMALL_W'(CYCLE_LEN - 1);

  assign at_fast0  = small_cnt == '0;
  assign at_fast1  = small_cnt == SMALL_W'(GB1_POS);
  assign at_slow   = small_cnt == SMALL_W'(MB_POS);
  assign slow_step = !big_cnt[0] && (big_cnt >= BIG_W'(4));  // steps 4,6..14

  // ----------------------------------------
  // trigger decode
  // ----------------------------------------
  assign trg_slot    = at_fast0 || at_fast1 || (at_slow && slow_step);
  assign trg_index   = at_fast0 ? SLOT_W'(0) :
                       at_fast1 ? SLOT_W'(1) : big_cnt[BIG_W-1:1];
  assign refresh_req = at_fast0 && big_cnt[0];  // odd big steps

  always_ff @(posedge CLK)
    if (!RST)
    begin
      small_cnt <= SMALL_W'(CYCLE_LEN + 1);  // out of range until first wrap
      big_cnt   <= BIG_W'(3);
    end
    else if (small_wrap)
    begin
      small_cnt <= '0;
      big_cnt   <= big_cnt + 1'b1;
    end
    else
    begin
      small_cnt <= small_cnt + 1'b1;
    end

endmodule

`default_nettype wire

// ==== hdl/block_splitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_splitter (
  input  wire                          CLK,
  input  wire                          RST,
  exec_if.splitter                     exec,
  // block mover
  output logic [sched_pkg::OFFS_W-1:0] blck_start,
  output logic [sched_pkg::BLK_W-1:0]  blck_count_req,
  output logic                         blck_issue,
  output logic [sched_pkg::SECT_W-1:0] blck_section,
  input  wire  [sched_pkg::BLK_W-1:0]  blck_count_sent,
  input  wire                          blck_working,
  // memory controller
  output logic [sched_pkg::PAGE_W-1:0] mcu_page_addr,
  output logic                         mcu_request_align,
  input  wire                          mcu_grant_align
);
  import sched_pkg::*;

  // one-hot state bits
  localparam int S_LOAD = 0;
  localparam int S_SIZE = 1;
  localparam int S_MOVE = 2;
  localparam int S_IDLE = 3;

  logic [3:0]        state;
  logic              working_prev, issued, clipped;
  logic [1:0]        issue_op;
  logic              carry_low, add_high;
  logic [7:0]        old_low;
  logic [ADDR_W-9:0] old_high;
  logic              do_go, mover_done, fire, crosses;
  logic [OFFS_W:0]   end_addr;
  logic [BLK_W-1:0]  to_page_end;

  assign exec.ready    = state[S_IDLE];
  assign exec.old_addr = {old_high, old_low};

  assign blck_issue = issue_op[0] ^ issue_op[1];  // one pulse per toggle

  assign do_go      = exec.go && state[S_IDLE];
  assign mover_done = state[S_MOVE] && working_prev && !blck_working && !add_high;

  // an exact fit to the page end is not a cut
  assign end_addr    = {1'b0, blck_start} + exec.block_length;
  assign crosses     = end_addr[OFFS_W] && (end_addr[OFFS_W-1:0] != '0);
  assign to_page_end = ~blck_start[BLK_W-1:0] + 1'b1;

  // grant seen and mover quiet for two cycles
  assign fire = mcu_request_align && mcu_grant_align && !issued && !blck_issue &&
                !blck_working && !working_prev && (state[S_SIZE] || state[S_MOVE]);

  // ----------------------------------------
  // control
  // ----------------------------------------
  always_ff @(posedge CLK)
    if (!RST)
    begin
      state             <= 4'b1000;
      working_prev      <= 1'b0;
      issue_op          <= 2'b00;
      issued            <= 1'b0;
      mcu_request_align <= 1'b0;
      add_high          <= 1'b0;
      exec.endof_page   <= 1'b0;
    end
    else
    begin
      working_prev <= blck_working;
      if (do_go || state[S_LOAD] || state[S_SIZE])
        state <= {state[2:0], do_go};  // idle -> load -> size -> move
      else if (state[S_MOVE] && add_high)
        state <= 4'b1000;              // back with old_addr complete

      if (state[S_LOAD])
      begin
        mcu_request_align <= 1'b1;
        issued            <= 1'b0;
      end
      else if (fire)
        issued <= 1'b1;
      if (fire)
        issue_op[0] <= ~issue_op[0];
      issue_op[1] <= issue_op[0];

      add_high <= mover_done;
      if (mover_done)
      begin
        mcu_request_align <= 1'b0;
        exec.endof_page   <= clipped && (blck_count_req == blck_count_sent);
      end
    end

  // ----------------------------------------
  // block fields and address update
  // ----------------------------------------
  always_ff @(posedge CLK)
  begin
    if (state[S_LOAD])
    begin
      mcu_page_addr <= exec.new_addr[ADDR_W-1:OFFS_W];
      blck_start    <= exec.new_addr[OFFS_W-1:0];
      blck_section  <= exec.new_section;
    end
    if (state[S_SIZE])
    begin
      clipped        <= crosses;
      blck_count_req <= crosses ? to_page_end : exec.block_length;
    end
    if (mover_done)
    begin
      {carry_low, old_low} <= blck_start[7:0] + {2'b00, blck_count_sent};  // low stage
      exec.count_sent      <= blck_count_sent;
    end
    if (add_high)
      old_high <= {mcu_page_addr, blck_start[OFFS_W-1:8]} + carry_low;
  end

endmodule

`default_nettype wire

// ==== hdl/trans_sched.sv ====
`timescale 1ns/1ps
`default_nettype none

module trans_sched (
  input  wire                          CLK,
  input  wire                          RST,
  input  wire                          trg_slot,
  input  wire  [sched_pkg::SLOT_W-1:0] trg_index,
  input  wire                          refresh_req,
  output logic                         rd_sched,
  output logic [sched_pkg::SLOT_W-1:0] rd_addr,
  input  wire  sched_pkg::desc_t       rd_data,
  output logic                         wr_sched,
  output logic [sched_pkg::SLOT_W-1:0] wr_addr,
  output sched_pkg::desc_t             wr_data,
  exec_if.sched                        exec,
  output logic                         mcu_refresh_strobe
);
  import sched_pkg::*;

  logic [1:0]        trans_req, trans_ack, rfr_req, rfr_ack;
  logic [SLOT_W-1:0] slot_s0, slot_s1, slot_s2;   // saved slot index stages
  logic              trg_d1, trg_d2, ready_prev;
  logic              ready_rise, trans_pend, rfr_pend, idle;
  logic              desc_ok, take, launch, do_refresh, cont, last_blk;
  logic [ADDR_W-1:0] addr_s;
  logic [SECT_W-1:0] sect_s;
  logic [LEN_W-1:0]  len_s, len_left, len_wb;
  logic [BLK_W-1:0]  first_len;

  assign rd_sched = trg_slot;
  assign rd_addr  = trg_index;

  assign ready_rise = exec.ready && !ready_prev;
  assign trans_pend = trans_req != trans_ack;
  assign rfr_pend   = rfr_req != rfr_ack;
  assign idle       = exec.ready && !exec.go && !ready_rise;

  assign desc_ok    = rd_data.f.active && (rd_data.f.len != '0);
  assign take       = trg_d2 && desc_ok && idle && !trans_pend;  // else dropped
  assign launch     = idle && trans_pend && !rfr_pend;
  assign do_refresh = idle && rfr_pend;
  assign cont       = ready_rise && exec.endof_page;  // rest of a cut block

  assign last_blk  = len_s[LEN_W-1:BLK_W] == '0;
  assign first_len = last_blk ? len_s[BLK_W-1:0] : '1;
  assign len_wb    = len_left - LEN_W'(exec.count_sent);

  always_ff @(posedge CLK)
    if (!RST)
    begin
      trans_req <= '0;
      trans_ack <= '0;
      rfr_req   <= '0;
      rfr_ack   <= '0;
      trg_d1    <= 1'b0;
      trg_d2    <= 1'b0;
      ready_prev         <= 1'b1;   // splitter starts idle
      wr_sched           <= 1'b0;
      exec.go            <= 1'b0;
      mcu_refresh_strobe <= 1'b0;
    end
    else
    begin
      ready_prev <= exec.ready;
      trg_d1     <= trg_slot;
      trg_d2     <= trg_d1;         // read data valid here
      wr_sched   <= ready_rise && !exec.endof_page;
      if (refresh_req)
        rfr_req <= rfr_req + 1'b1;
      if (do_refresh)
      begin
        rfr_ack            <= rfr_ack + 1'b1;
        mcu_refresh_strobe <= !mcu_refresh_strobe;
      end
      if (take)
        trans_req <= trans_req + 1'b1;
      if (launch)
        trans_ack <= trans_ack + 1'b1;
      if (launch || cont)
        exec.go <= 1'b1;
      else if (!exec.ready)
        exec.go <= 1'b0;
    end

  // ----------------------------------------
  // descriptor fields and write-back word
  // ----------------------------------------
  always_ff @(posedge CLK)
  begin
    if (trg_slot)
      slot_s0 <= trg_index;
    if (take)
    begin
      slot_s1 <= slot_s0;
      addr_s  <= rd_data.f.addr;
      sect_s  <= rd_data.f.section;
      len_s   <= rd_data.f.len;
    end
    if (launch)
    begin
      slot_s2           <= slot_s1;
      len_left          <= len_s;
      exec.block_length <= first_len;
      exec.new_addr     <= addr_s;
      exec.new_section  <= sect_s;
    end
    else if (cont)
    begin
      exec.block_length <= exec.block_length - exec.count_sent;
      exec.new_addr     <= exec.old_addr;
    end
    if (ready_rise)
      len_left <= len_wb;
    if (ready_rise && !exec.endof_page)
    begin
      wr_addr           <= slot_s2;
      wr_data.f.active  <= len_wb != '0;   // done at zero length
      wr_data.f.section <= exec.new_section;
      wr_data.f.len     <= len_wb;
      wr_data.f.addr    <= exec.old_addr;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/sched_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sched_top #(
  parameter int CYCLE_LEN = 192
) (
  input  wire                          CLK,
  input  wire                          RST,
  // cpu descriptor port
  input  wire                          read_cpu,
  input  wire                          write_cpu,
  output logic                         read_cpu_ack,
  output logic                         write_cpu_ack,
  input  wire  [sched_pkg::SLOT_W-1:0] addr_cpu,
  input  wire  sched_pkg::desc_t       in_cpu,
  output logic [31:0]                  out_cpu,
  // block mover
  output logic [sched_pkg::OFFS_W-1:0] blck_start,
  output logic [sched_pkg::BLK_W-1:0]  blck_count_req,
  output logic                         blck_issue,
  output logic [sched_pkg::SECT_W-1:0] blck_section,
  input  wire  [sched_pkg::BLK_W-1:0]  blck_count_sent,
  input  wire                          blck_working,
  // memory controller
  output logic [sched_pkg::PAGE_W-1:0] mcu_page_addr,
  output logic                         mcu_request_align,
  input  wire                          mcu_grant_align,
  output logic                         mcu_refresh_strobe
);
  import sched_pkg::*;

  logic              trg_slot, refresh_req, rd_sched, wr_sched;
  logic [SLOT_W-1:0] trg_index, rd_addr, wr_addr;
  desc_t             rd_data, wr_data;

  exec_if exec ();

  desc_mem u_mem (
    .CLK, .RST,
    .read_cpu, .write_cpu, .read_cpu_ack, .write_cpu_ack,
    .addr_cpu, .in_cpu, .out_cpu,
    .rd_sched, .rd_addr, .rd_data, .wr_sched, .wr_addr, .wr_data
  );

  slot_carousel #(.CYCLE_LEN(CYCLE_LEN)) u_carousel (
    .CLK, .RST, .trg_slot, .trg_index, .refresh_req
  );

  trans_sched u_sched (
    .CLK, .RST, .trg_slot, .trg_index, .refresh_req,
    .rd_sched, .rd_addr, .rd_data, .wr_sched, .wr_addr, .wr_data,
    .exec(exec.sched), .mcu_refresh_strobe
  );

  block_splitter u_split (
    .CLK, .RST, .exec(exec.splitter),
    .blck_start, .blck_count_req, .blck_issue, .blck_section,
    .blck_count_sent, .blck_working,
    .mcu_page_addr, .mcu_request_align, .mcu_grant_align
  );

endmodule

`default_nettype wire

// ==== dv/tb_sched_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sched_top;
  import sched_pkg::*;

  localparam int CYCLE       = 192;
  localparam int CLK_NS      = 10;
  localparam int WAIT_MAX    = 16 * CYCLE + 400;         // one full big carousel plus margin
  localparam int WATCHDOG_NS = 20 * CYCLE * 16 * CLK_NS;
  localparam logic [31:0] SEED = 32'h2f302a58;

  logic              CLK = 1'b0;
  logic              RST;
  logic              read_cpu, write_cpu, read_cpu_ack, write_cpu_ack;
  logic [SLOT_W-1:0] addr_cpu;
  desc_t             in_cpu;
  logic [31:0]       out_cpu;
  logic [OFFS_W-1:0] blck_start;
  logic [BLK_W-1:0]  blck_count_req, blck_count_sent;
  logic              blck_issue, blck_working;
  logic [SECT_W-1:0] blck_section;
  logic [PAGE_W-1:0] mcu_page_addr;
  logic              mcu_request_align, mcu_grant_align, mcu_refresh_strobe;

  int                cyc;                                // clocks since reset release
  int                n_wr_ack, n_rd_ack, n_issue, n_refresh;
  int                mover_left, last_cyc;
  logic              req_d, grant_q, grant_hold, strobe_prev;
  logic [OFFS_W-1:0] last_start;
  logic [BLK_W-1:0]  last_count;
  logic [PAGE_W-1:0] last_page;
  logic [SECT_W-1:0] last_section;

  sched_top #(.CYCLE_LEN(CYCLE)) dut0 (
    .CLK, .RST,
    .read_cpu, .write_cpu, .read_cpu_ack, .write_cpu_ack, .addr_cpu, .in_cpu, .out_cpu,
    .blck_start, .blck_count_req, .blck_issue, .blck_section,
    .blck_count_sent, .blck_working,
    .mcu_page_addr, .mcu_request_align, .mcu_grant_align, .mcu_refresh_strobe
  );

  initial
    forever #(CLK_NS / 2) CLK = ~CLK;

  always @(posedge CLK)
    if (!RST)
      cyc <= 0;
    else
      cyc <= cyc + 1;

  // ----------------------------------------
  // mover and controller models, monitors
  // ----------------------------------------
  always @(negedge CLK)
  begin
    if (blck_issue)
    begin
      blck_working    <= 1'b1;
      blck_count_sent <= blck_count_req;   // mover always sends all
      mover_left      <= blck_count_req + 2;
    end
    else if (mover_left > 1)
      mover_left <= mover_left - 1;
    else if (mover_left == 1)
    begin
      mover_left   <= 0;
      blck_working <= 1'b0;
    end
  end

  always @(negedge CLK)
  begin
    req_d   <= mcu_request_align;
    grant_q <= mcu_request_align && req_d;  // grant a cycle after the request
  end

  assign mcu_grant_align = grant_q && !grant_hold;

  always @(negedge CLK)
  begin
    if (write_cpu_ack)
      n_wr_ack <= n_wr_ack + 1;
    if (read_cpu_ack)
      n_rd_ack <= n_rd_ack + 1;
    strobe_prev <= mcu_refresh_strobe;
    if (mcu_refresh_strobe != strobe_prev)
      n_refresh <= n_refresh + 1;
    if (blck_issue)
    begin
      n_issue      <= n_issue + 1;
      last_start   <= blck_start;
      last_count   <= blck_count_req;
      last_page    <= mcu_page_addr;
      last_section <= blck_section;
      last_cyc     <= cyc;
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("Regression failed");
    $fatal(1, "watchdog");
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      $display("Regression failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "stopped on timeout");
  endtask

  function automatic desc_t make_desc(input logic act, input logic [SECT_W-1:0] sect,
                                      input logic [LEN_W-1:0] len,
                                      input logic [ADDR_W-1:0] addr);
    desc_t d;
    d.f.active  = act;
    d.f.section = sect;
    d.f.len     = len;
    d.f.addr    = addr;
    return d;
  endfunction

  task automatic cpu_write(input logic [SLOT_W-1:0] slot, input desc_t d);
    int n;
    int acks0;
    n     = 0;
    acks0 = n_wr_ack;
    addr_cpu  = slot;
    in_cpu    = d;
    write_cpu = 1'b1;
    while (!write_cpu_ack)
    begin
      @(negedge CLK);
      n++;
      if (n > 50)
        abort_run("no write ack came back from the CPU port");
    end
    write_cpu = 1'b0;
    repeat (2) @(negedge CLK);
    check_val("write_cpu_ack count", n_wr_ack - acks0, 1);
  endtask

  task automatic cpu_read(input logic [SLOT_W-1:0] slot, output logic [31:0] hi);
    int n;
    int acks0;
    n     = 0;
    acks0 = n_rd_ack;
    addr_cpu = slot;
    read_cpu = 1'b1;
    while (!read_cpu_ack)
    begin
      @(negedge CLK);
      n++;
      if (n > 50)
        abort_run("no read ack came back from the CPU port");
    end
    read_cpu = 1'b0;
    @(negedge CLK);
    hi = out_cpu;       // valid one clock after the ack
    @(negedge CLK);
    check_val("read_cpu_ack count", n_rd_ack - acks0, 1);
  endtask

  // poll until the write-back shows up
  task automatic wait_hi(input logic [SLOT_W-1:0] slot, input logic [31:0] exp);
    logic [31:0] hi;
    int          n;
    n = 0;
    cpu_read(slot, hi);
    while (hi !== exp && n < 400)
    begin
      cpu_read(slot, hi);
      n++;
    end
    check_val("out_cpu", hi, exp);
  endtask

  task automatic wait_issues(input int target);
    int n;
    n = 0;
    while (n_issue < target)
    begin
      @(negedge CLK);
      n++;
      if (n > WAIT_MAX)
        abort_run("timed out waiting for a block issue");
    end
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic cpu_access_test();
    desc_t       d [NUM_SLOTS];
    logic [31:0] hi;
    for (int i = 0; i < NUM_SLOTS; i++)
    begin
      d[i] = {$urandom(), $urandom()};
      d[i].f.active = 1'b0;             // keep the scheduler out of it
      cpu_write(SLOT_W'(i), d[i]);
    end
    for (int i = 0; i < NUM_SLOTS; i++)
    begin
      cpu_read(SLOT_W'(i), hi);
      check_val("out_cpu", hi, d[i].raw.hi);
    end
  endtask

  task automatic fast_block_test();
    logic [PAGE_W-1:0] page;
    logic [OFFS_W-1:0] offs;
    logic [SECT_W-1:0] sect;
    desc_t             d;
    int                base;
    page = PAGE_W'($urandom());
    offs = OFFS_W'(100 + $urandom() % 3000);
    sect = SECT_W'($urandom());
    base = n_issue;
    cpu_write(0, make_desc(1'b1, sect, 40, {page, offs}));
    wait_issues(base + 1);
    check_val("blck_count_req", last_count, 40);
    check_val("blck_start", last_start, offs);
    check_val("mcu_page_addr", last_page, page);
    check_val("blck_section", last_section, sect);
    d = make_desc(1'b0, sect, 0, 0);
    wait_hi(0, d.raw.hi);
    check_val("blck_issue count", n_issue - base, 1);
  endtask

  task automatic length_cap_test();
    logic [PAGE_W-1:0] page;
    logic [OFFS_W-1:0] offs;
    logic [SECT_W-1:0] sect;
    desc_t             d;
    int                base;
    page = PAGE_W'($urandom());
    offs = OFFS_W'(200 + $urandom() % 1000);
    sect = SECT_W'($urandom());
    base = n_issue;
    cpu_write(1, make_desc(1'b1, sect, 100, {page, offs}));
    wait_issues(base + 1);
    check_val("blck_count_req", last_count, 63);
    check_val("blck_start", last_start, offs);
    d = make_desc(1'b1, sect, 37, 0);
    wait_hi(1, d.raw.hi);
    wait_issues(base + 2);                  // next slot-1 trigger
    check_val("blck_count_req", last_count, 37);
    check_val("blck_start", last_start, offs + 12'd63);
    check_val("mcu_page_addr", last_page, page);
    d = make_desc(1'b0, sect, 0, 0);
    wait_hi(1, d.raw.hi);
  endtask

  task automatic page_split_test();
    logic [PAGE_W-1:0] page;
    logic [OFFS_W-1:0] offs;
    logic [SECT_W-1:0] sect;
    desc_t             d;
    int                base;
    page = PAGE_W'($urandom());
    offs = OFFS_W'(4096 - 10);              // 10 words before the page end
    sect = SECT_W'($urandom());
    base = n_issue;
    cpu_write(0, make_desc(1'b1, sect, 30, {page, offs}));
    wait_issues(base + 1);
    check_val("blck_count_req", last_count, 10);
    check_val("blck_start", last_start, offs);
    check_val("mcu_page_addr", last_page, page);
    wait_issues(base + 2);
    check_val("blck_count_req", last_count, 20);
    check_val("blck_start", last_start, 0);
    check_val("mcu_page_addr", last_page, PAGE_W'(page + 1));
    d = make_desc(1'b0, sect, 0, 0);
    wait_hi(0, d.raw.hi);
    check_val("descriptor addr", dut0.u_mem.mem[0].raw.lo, {page, offs} + 32'd30);
  endtask

  task automatic slow_slot_test();
    desc_t d;
    int    base, pos, step, small_pos, rfr0;
    base = n_issue;
    cpu_write(4, make_desc(1'b1, 2'd1, 5, 32'h0001_0040));
    wait_issues(base + 1);
    // carousel starts at big step 4, small position 0 after the first clock
    pos       = (last_cyc - 1) % (16 * CYCLE);
    step      = (4 + pos / CYCLE) % 16;
    small_pos = pos % CYCLE;
    check_val("slow slot big step", step, 8);
    check_val("slow slot near MB_POS", small_pos >= MB_POS && small_pos < MB_POS + 24, 1);
    check_val("blck_count_req", last_count, 5);
    d = make_desc(1'b0, 2'd1, 0, 0);
    wait_hi(4, d.raw.hi);
    while ((cyc - 1) % CYCLE != CYCLE / 2)
      @(negedge CLK);
    rfr0 = n_refresh;
    repeat (16 * CYCLE) @(negedge CLK);
    check_val("mcu_refresh_strobe toggles", n_refresh - rfr0, 8);
  endtask

  task automatic align_gate_test();
    desc_t d;
    int    base, n;
    base = n_issue;
    n    = 0;
    grant_hold = 1'b1;
    cpu_write(1, make_desc(1'b1, 2'd2, 8, 32'h0002_0100));
    while (!mcu_request_align)
    begin
      @(negedge CLK);
      n++;
      if (n > WAIT_MAX)
        abort_run("alignment request never rose");
    end
    repeat (40)
    begin
      @(negedge CLK);
      check_val("mcu_request_align", mcu_request_align, 1);
    end
    check_val("blck_issue count while held", n_issue - base, 0);
    grant_hold = 1'b0;
    wait_issues(base + 1);
    check_val("blck_count_req", last_count, 8);
    d = make_desc(1'b0, 2'd2, 0, 0);
    wait_hi(1, d.raw.hi);
    check_val("blck_issue count", n_issue - base, 1);
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial
  begin
    void'($urandom(SEED));
    RST             = 1'b0;
    read_cpu        = 1'b0;
    write_cpu       = 1'b0;
    addr_cpu        = '0;
    in_cpu          = '0;
    blck_working    = 1'b0;
    blck_count_sent = '0;
    mover_left      = 0;
    req_d           = 1'b0;
    grant_q         = 1'b0;
    grant_hold      = 1'b0;
    strobe_prev     = 1'b0;
    n_wr_ack        = 0;
    n_rd_ack        = 0;
    n_issue         = 0;
    n_refresh       = 0;
    last_cyc        = 0;
    repeat (10) @(negedge CLK);
    RST = 1'b1;
    cpu_access_test();
    fast_block_test();
    length_cap_test();
    page_split_test();
    slow_slot_test();
    align_gate_test();
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/sched_pkg.sv
hdl/exec_if.sv
hdl/desc_mem.sv
hdl/slot_carousel.sv
hdl/block_splitter.sv
hdl/trans_sched.sv
hdl/sched_top.sv
dv/tb_sched_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run tb_sched_top with Verilator, fail if the log holds the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_sched_top -f sim.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "Regression failed" >> sim.log
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0
